// File: Bender.yml
package:
  name: ooo_backend

export_include_dirs:
  - include

sources:
  - hdl/ooo_pkg.sv
  - hdl/issue_decode.sv
  - hdl/alu_unit.sv
  - hdl/mult_unit.sv
  - hdl/rob.sv
  - hdl/retire_unit.sv
  - hdl/ooo_backend_top.sv
  - target: simulation
    files:
      - sim/ooo_assertions.sv
      - sim/clock_gen.sv
      - sim/ooo_tb.sv

// File: hdl/alu_unit.sv
`default_nettype none

module alu_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  ooo_pkg::exec_op_t  op,
    input  logic               flush,
    output ooo_pkg::complete_t done
);
    import ooo_pkg::*;

    exec_op_t op_q;
    data_t    result;
    logic     trap;

    always_comb begin
        result = '0;
        trap   = 1'b0;
        case (op_q.opcode)
            OP_ADD:  result = op_q.src_a + op_q.src_b;
            OP_SUB:  result = op_q.src_a - op_q.src_b;
            OP_AND:  result = op_q.src_a & op_q.src_b;
            OP_XOR:  result = op_q.src_a ^ op_q.src_b;
            OP_TRAP: trap = 1'b1;
            default: result = '0;
        endcase
    end

    // operand capture, then the result register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q <= '0;
            done <= '0;
        end else begin
            op_q       <= op;
            op_q.valid <= op.valid && !flush;
            done.valid  <= op_q.valid && !flush;
            done.slot   <= op_q.slot;
            done.result <= result;
            done.exc    <= trap;
        end
    end

endmodule

`default_nettype wire

// File: hdl/issue_decode.sv
`default_nettype none

module issue_decode (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              issue,
    input  ooo_pkg::instr_t   issue_instr,
    input  logic              rob_full,
    input  ooo_pkg::rob_idx_t tail_idx,
    output logic              alloc,
    output ooo_pkg::reg_idx_t alloc_rd,
    output ooo_pkg::exec_op_t alu_op,
    output ooo_pkg::exec_op_t mul_op
);
    import ooo_pkg::*;

    logic        accept;
    logic        is_mul;
    logic [15:0] drop_cnt;
    exec_op_t    op;

    assign accept = issue && !rob_full;
    assign is_mul = issue_instr.opcode == OP_MUL;

    assign alloc    = accept;
    assign alloc_rd = issue_instr.rd;

    // common payload, tagged with the slot being allocated
    always_comb begin
        op.valid  = 1'b0;
        op.opcode = issue_instr.opcode;
        op.src_a  = issue_instr.src_a;
        op.src_b  = issue_instr.src_b;
        op.slot   = tail_idx;
    end

    // steer by opcode class
    always_comb begin
        alu_op       = op;
        mul_op       = op;
        alu_op.valid = accept && !is_mul;
        mul_op.valid = accept && is_mul;
    end

    // issues lost to a full buffer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drop_cnt <= '0;
        end else if (issue && rob_full) begin
            drop_cnt <= drop_cnt + 16'd1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mult_unit.sv
`default_nettype none

`include "ooo_config.svh"

module mult_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  ooo_pkg::exec_op_t  op,
    input  logic               flush,
    output ooo_pkg::complete_t done
);
    import ooo_pkg::*;

    localparam int LAT = `OOO_MULT_LATENCY;

    logic     in_vld;
    data_t    in_a;
    data_t    in_b;
    rob_idx_t in_slot;

    logic     stage_vld  [LAT];
    rob_idx_t stage_slot [LAT];
    data_t    stage_prod [LAT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_vld <= 1'b0;
            for (int i = 0; i < LAT; i++) begin
                stage_vld[i] <= 1'b0;
            end
        end else begin
            in_vld       <= op.valid && !flush;
            stage_vld[0] <= in_vld && !flush;
            for (int i = 1; i < LAT; i++) begin
                stage_vld[i] <= stage_vld[i-1] && !flush;
            end
        end
    end

    // payload only follows the valids
    always_ff @(posedge clk) begin
        in_a          <= op.src_a;
        in_b          <= op.src_b;
        in_slot       <= op.slot;
        stage_slot[0] <= in_slot;
        stage_prod[0] <= in_a * in_b;
        for (int i = 1; i < LAT; i++) begin
            stage_slot[i] <= stage_slot[i-1];
            stage_prod[i] <= stage_prod[i-1];
        end
    end

    always_comb begin
        done.valid  = stage_vld[LAT-1];
        done.slot   = stage_slot[LAT-1];
        done.result = stage_prod[LAT-1];
        done.exc    = 1'b0;
    end

endmodule

`default_nettype wire

// File: hdl/ooo_backend_top.sv
`default_nettype none

`include "ooo_config.svh"

module ooo_backend_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue,
    input  ooo_pkg::instr_t      issue_instr,
    output logic                 rob_full,
    output ooo_pkg::retire_t     retire_out,
    output logic                 exception,
    output logic [31:0]          instret,
    input  ooo_pkg::reg_idx_t    reg_addr,
    output logic [`OOO_XLEN-1:0] reg_data
);
    import ooo_pkg::*;

    rob_idx_t  tail_idx;
    logic      alloc;
    reg_idx_t  alloc_rd;
    exec_op_t  alu_op;
    exec_op_t  mul_op;
    complete_t alu_done;
    complete_t mul_done;
    retire_t   head_entry;
    logic      retire_ack;
    logic      flush;

    issue_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue       (issue),
        .issue_instr (issue_instr),
        .rob_full    (rob_full),
        .tail_idx    (tail_idx),
        .alloc       (alloc),
        .alloc_rd    (alloc_rd),
        .alu_op      (alu_op),
        .mul_op      (mul_op)
    );

    alu_unit u_alu (
        .clk   (clk),
        .rst_n (rst_n),
        .op    (alu_op),
        .flush (flush),
        .done  (alu_done)
    );

    mult_unit u_mult (
        .clk   (clk),
        .rst_n (rst_n),
        .op    (mul_op),
        .flush (flush),
        .done  (mul_done)
    );

    rob u_rob (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .alloc      (alloc),
        .alloc_rd   (alloc_rd),
        .alu_done   (alu_done),
        .mul_done   (mul_done),
        .retire_ack (retire_ack),
        .tail_idx   (tail_idx),
        .full       (rob_full),
        .head_entry (head_entry)
    );

    retire_unit u_retire (
        .clk        (clk),
        .rst_n      (rst_n),
        .head_entry (head_entry),
        .retire_ack (retire_ack),
        .retire_out (retire_out),
        .exception  (exception),
        .flush      (flush),
        .instret    (instret),
        .reg_addr   (reg_addr),
        .reg_data   (reg_data)
    );

endmodule

`default_nettype wire

// File: hdl/ooo_pkg.sv
`default_nettype none

`include "ooo_config.svh"

package ooo_pkg;

    localparam int ROB_IDX_W = $clog2(`OOO_ROB_DEPTH);
    localparam int REG_IDX_W = $clog2(`OOO_NUM_REGS);

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_XOR,
        OP_MUL,
        OP_TRAP
    } opcode_e;

    typedef logic [`OOO_XLEN-1:0] data_t;
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;
    // extra msb tells full from empty
    typedef logic [ROB_IDX_W:0]   rob_ptr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rd;
        data_t    src_a;
        data_t    src_b;
    } instr_t;

    typedef struct packed {
        logic     valid;
        opcode_e  opcode;
        data_t    src_a;
        data_t    src_b;
        rob_idx_t slot;
    } exec_op_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t slot;
        data_t    result;
        logic     exc;
    } complete_t;

    typedef struct packed {
        logic     busy;
        logic     complete;
        logic     exc;
        reg_idx_t rd;
        data_t    result;
    } rob_entry_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t slot;
        reg_idx_t rd;
        data_t    value;
        logic     exc;
    } retire_t;

endpackage

`default_nettype wire

// File: hdl/retire_unit.sv
`default_nettype none

`include "ooo_config.svh"

module retire_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  ooo_pkg::retire_t         head_entry,
    output logic                     retire_ack,
    output ooo_pkg::retire_t         retire_out,
    output logic                     exception,
    output logic                     flush,
    output logic [31:0]              instret,
    input  ooo_pkg::reg_idx_t        reg_addr,
    output logic [`OOO_XLEN-1:0]     reg_data
);
    import ooo_pkg::*;

    localparam int NREGS = `OOO_NUM_REGS;

    data_t regs [NREGS];

    // nothing retires while the flush is in progress
    assign retire_ack = head_entry.valid && !flush;
    assign flush      = exception;

    assign reg_data = regs[reg_addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_out <= '0;
            exception  <= 1'b0;
            instret    <= '0;
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            retire_out       <= head_entry;
            retire_out.valid <= retire_ack;
            exception        <= retire_ack && head_entry.exc;
            if (retire_ack) begin
                instret <= instret + 32'd1;
                // a trapping entry leaves the register file alone
                if (!head_entry.exc) begin
                    regs[head_entry.rd] <= head_entry.value;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/rob.sv
`default_nettype none

`include "ooo_config.svh"

module rob (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               alloc,
    input  ooo_pkg::reg_idx_t  alloc_rd,
    input  ooo_pkg::complete_t alu_done,
    input  ooo_pkg::complete_t mul_done,
    input  logic               retire_ack,
    output ooo_pkg::rob_idx_t  tail_idx,
    output logic               full,
    output ooo_pkg::retire_t   head_entry
);
    import ooo_pkg::*;

    localparam int DEPTH   = `OOO_ROB_DEPTH;
    localparam int N_DONE  = 2;

    rob_entry_t entries_q [DEPTH];
    rob_ptr_t   head_q;
    rob_ptr_t   tail_q;
    rob_idx_t   head_idx;
    logic       wrap_diff;
    logic       idx_same;
    logic       empty;
    complete_t  done_in [N_DONE];
    rob_entry_t head_view;

    assign head_idx = head_q[ROB_IDX_W-1:0];
    assign tail_idx = tail_q[ROB_IDX_W-1:0];

    // same slot, wrap bits differ -> full
    assign wrap_diff = head_q[ROB_IDX_W] ^ tail_q[ROB_IDX_W];
    assign idx_same  = head_idx == tail_idx;
    assign full      = wrap_diff && idx_same;
    assign empty     = !wrap_diff && idx_same;

    assign done_in[0] = alu_done;
    assign done_in[1] = mul_done;

    // head entry with this cycle's completions folded in,
    // so a result can retire the cycle it arrives
    always_comb begin
        head_view = entries_q[head_idx];
        for (int d = 0; d < N_DONE; d++) begin
            if (done_in[d].valid && done_in[d].slot == head_idx) begin
                head_view.complete = 1'b1;
                head_view.exc      = done_in[d].exc;
                head_view.result   = done_in[d].result;
            end
        end
    end

    always_comb begin
        head_entry.valid = !empty && head_view.busy && head_view.complete;
        head_entry.slot  = head_idx;
        head_entry.rd    = head_view.rd;
        head_entry.value = head_view.result;
        head_entry.exc   = head_view.exc;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q <= '0;
            tail_q <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                entries_q[i] <= '0;
            end
        end else if (flush) begin
            // drop everything in flight, late completions included
            head_q <= '0;
            tail_q <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                entries_q[i].busy     <= 1'b0;
                entries_q[i].complete <= 1'b0;
            end
        end else begin
            for (int d = 0; d < N_DONE; d++) begin
                if (done_in[d].valid && entries_q[done_in[d].slot].busy) begin
                    entries_q[done_in[d].slot].complete <= 1'b1;
                    entries_q[done_in[d].slot].exc      <= done_in[d].exc;
                    entries_q[done_in[d].slot].result   <= done_in[d].result;
                end
            end

            // free the head after any completion write to it
            if (retire_ack) begin
                entries_q[head_idx].busy     <= 1'b0;
                entries_q[head_idx].complete <= 1'b0;
                head_q <= head_q + rob_ptr_t'(1);
            end

            if (alloc && !full) begin
                entries_q[tail_idx] <= '{
                    busy:     1'b1,
                    complete: 1'b0,
                    exc:      1'b0,
                    rd:       alloc_rd,
                    result:   '0
                };
                tail_q <= tail_q + rob_ptr_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: include/ooo_config.svh
`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

// datapath width
`define OOO_XLEN 32

// reorder buffer entries, power of two
`define OOO_ROB_DEPTH 8

// architectural registers
`define OOO_NUM_REGS 8

// multiplier pipeline stages
`define OOO_MULT_LATENCY 3

`endif

// File: project.f
+incdir+include
hdl/ooo_pkg.sv
hdl/issue_decode.sv
hdl/alu_unit.sv
hdl/mult_unit.sv
hdl/rob.sv
hdl/retire_unit.sv
hdl/ooo_backend_top.sv
sim/ooo_assertions.sv
sim/clock_gen.sv
sim/ooo_tb.sv

// File: sim/clock_gen.sv
`default_nettype none

module clock_gen (
    output logic clk,
    output logic rst_n
);
    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: sim/ooo_assertions.sv
`default_nettype none

module ooo_assertions (
    input logic              clk,
    input logic              rst_n,
    input logic              flush,
    input logic              full,
    input logic              empty,
    input logic              head_busy,
    input ooo_pkg::rob_ptr_t tail_q
);
    int fail_cnt = 0;

    // pointer occupancy has to agree with the busy bit at the head
    full_empty_excl: assert property (@(posedge clk) disable iff (!rst_n)
        (!full || head_busy) && (!empty || !head_busy))
    else begin
        $error("rob full or empty level disagrees with the head busy bit");
        fail_cnt++;
    end

    flush_empties: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> empty)
    else begin
        $error("rob not empty after flush");
        fail_cnt++;
    end

    // tail holds while the buffer is full
    no_alloc_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        (full && !flush) |=> $stable(tail_q))
    else begin
        $error("allocation accepted while rob full");
        fail_cnt++;
    end

endmodule

bind rob ooo_assertions u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .full      (full),
    .empty     (empty),
    .head_busy (entries_q[head_idx].busy),
    .tail_q    (tail_q)
);

`default_nettype wire

// File: sim/ooo_tb.sv
`default_nettype none

`include "ooo_config.svh"

module ooo_tb;
    import ooo_pkg::*;

    localparam int DEPTH = `OOO_ROB_DEPTH;
    localparam int NREGS = `OOO_NUM_REGS;
    localparam logic [31:0] SEED = 32'd1734;

    // cycle budget per test
    localparam int RESET_LEN = 20;
    localparam int RESET_TEST_LEN = 12;
    localparam int ALU_TEST_LEN = 40;
    localparam int OOO_TEST_LEN = 30;
    localparam int MUL_TEST_LEN = 30;
    localparam int TRAP_TEST_LEN = 30;
    localparam int BURST_TEST_LEN = 35;
    localparam int MARGIN = 100;
    localparam int RUN_LIMIT = RESET_LEN + RESET_TEST_LEN + ALU_TEST_LEN + OOO_TEST_LEN
                             + MUL_TEST_LEN + TRAP_TEST_LEN + BURST_TEST_LEN + MARGIN;

    logic        clk;
    logic        rst_n;
    logic        issue;
    instr_t      issue_instr;
    logic        rob_full;
    retire_t     retire_out;
    logic        exception;
    logic [31:0] instret;
    reg_idx_t    reg_addr;
    data_t       reg_data;

    // reference model state
    retire_t     exp_q[$];
    data_t       model_regs [NREGS];
    logic [31:0] model_instret;
    rob_idx_t    model_tail;
    logic        flush_due;
    logic [31:0] rng;

    int errors;
    int checks;
    int test_err_base;
    int tests_run;
    int tests_failed;
    int retired;
    int accepted;
    int dropped;
    int exc_seen;
    int cycles;

    clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ooo_backend_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue       (issue),
        .issue_instr (issue_instr),
        .rob_full    (rob_full),
        .retire_out  (retire_out),
        .exception   (exception),
        .instret     (instret),
        .reg_addr    (reg_addr),
        .reg_data    (reg_data)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic data_t expected_result(input opcode_e opc, input data_t a, input data_t b);
        case (opc)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            OP_MUL:  return data_t'(a * b);
            default: return '0;
        endcase
    endfunction

    task automatic compare_retire(input string name, input retire_t got, input retire_t want);
        checks++;
        if (got !== want) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic compare_data(input string name, input data_t got, input data_t want);
        checks++;
        if (got !== want) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic compare_count(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        checks++;
        if (got !== want) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    // one cycle: sample outputs on the falling edge, update the model
    task automatic tick();
        retire_t want;
        logic    want_exc;
        @(negedge clk);
        issue     = 1'b0;
        flush_due = 1'b0;
        want_exc  = 1'b0;
        if (exception) begin
            exc_seen++;
        end
        if (retire_out.valid) begin
            retired++;
            if (exp_q.size() == 0) begin
                $display("unexpected retirement from slot %0d with nothing outstanding",
                         retire_out.slot);
                errors++;
            end else begin
                want = exp_q.pop_front();
                compare_retire("retire_out", retire_out, want);
                model_instret++;
                if (want.exc) begin
                    // younger entries are flushed, allocation restarts at slot 0
                    want_exc  = 1'b1;
                    flush_due = 1'b1;
                    exp_q.delete();
                    model_tail = '0;
                end else begin
                    model_regs[want.rd] = want.value;
                end
            end
        end
        compare_flag("exception", exception, want_exc);
        compare_count("instret", instret, model_instret);
        compare_flag("rob_full", rob_full, exp_q.size() == DEPTH);
    endtask

    task automatic issue_op(input opcode_e opc, input reg_idx_t rd, input data_t a,
                            input data_t b);
        retire_t want;
        tick();
        issue       = 1'b1;
        issue_instr = '{opcode: opc, rd: rd, src_a: a, src_b: b};
        if (exp_q.size() >= DEPTH) begin
            // buffer full, decode drops and counts it
            dropped++;
        end else if (!flush_due) begin
            want.valid = 1'b1;
            want.slot  = model_tail;
            want.rd    = rd;
            want.value = expected_result(opc, a, b);
            want.exc   = (opc == OP_TRAP);
            exp_q.push_back(want);
            model_tail++;
            accepted++;
        end
    endtask

    task automatic issue_random(input opcode_e opc);
        reg_idx_t rd;
        data_t    a;
        data_t    b;
        rng = xorshift32(rng);
        rd  = reg_idx_t'(rng);
        rng = xorshift32(rng);
        a   = rng;
        rng = xorshift32(rng);
        b   = rng;
        issue_op(opc, rd, a, b);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            tick();
        end
        // quiet period, nothing more may retire
        repeat (8) tick();
    endtask

    task automatic check_regs();
        for (int i = 0; i < NREGS; i++) begin
            reg_addr = reg_idx_t'(i);
            tick();
            compare_data($sformatf("reg_data[%0d]", i), reg_data, model_regs[i]);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_err_base) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: fail with %0d mismatches", name, errors - test_err_base);
            tests_failed++;
        end
    endtask

    task automatic test_reset_state();
        test_err_base = errors;
        tick();
        compare_count("instret", instret, 32'd0);
        compare_flag("exception", exception, 1'b0);
        compare_flag("rob_full", rob_full, 1'b0);
        check_regs();
        finish_test("reset_state");
    endtask

    task automatic test_alu_order();
        test_err_base = errors;
        for (int i = 0; i < 10; i++) begin
            rng = xorshift32(rng);
            issue_random(opcode_e'(rng[1:0]));
        end
        wait_drain();
        check_regs();
        finish_test("alu_order");
    endtask

    task automatic test_out_of_order();
        logic [31:0] base;
        test_err_base = errors;
        base = model_instret;
        issue_random(OP_MUL);
        issue_random(OP_ADD);
        issue_random(OP_ADD);
        wait_drain();
        compare_count("instret", instret, base + 32'd3);
        check_regs();
        finish_test("out_of_order");
    endtask

    task automatic test_mul_in_flight();
        test_err_base = errors;
        repeat (4) issue_random(OP_MUL);
        wait_drain();
        check_regs();
        finish_test("mul_in_flight");
    endtask

    task automatic test_trap_flush();
        int base_ret;
        int base_exc;
        test_err_base = errors;
        base_ret = retired;
        base_exc = exc_seen;
        issue_op(OP_ADD, 3'd1, 32'h0000_1000, 32'h0000_0234);
        issue_op(OP_SUB, 3'd2, 32'h0000_5000, 32'h0000_0001);
        issue_op(OP_XOR, 3'd3, 32'hA5A5_A5A5, 32'hFFFF_0000);
        issue_op(OP_TRAP, 3'd4, 32'h1111_1111, 32'h2222_2222);
        // younger, all of them must vanish
        issue_op(OP_MUL, 3'd5, 32'h0000_0123, 32'h0000_0456);
        issue_op(OP_ADD, 3'd6, 32'h7777_0000, 32'h0000_7777);
        issue_op(OP_MUL, 3'd1, 32'h0000_0FFF, 32'h0000_0FFF);
        wait_drain();
        compare_count("retirements", retired - base_ret, 32'd4);
        compare_count("exception pulses", exc_seen - base_exc, 32'd1);
        check_regs();
        finish_test("trap_flush");
    endtask

    // one issue and one retirement per cycle keep the buffer below full
    task automatic test_issue_burst();
        int base_ret;
        int base_acc;
        test_err_base = errors;
        base_ret = retired;
        base_acc = accepted;
        repeat (DEPTH + 1) issue_random(OP_MUL);
        wait_drain();
        compare_count("retirements", retired - base_ret, accepted - base_acc);
        compare_count("drop_cnt", DUT.u_decode.drop_cnt, dropped);
        check_regs();
        finish_test("issue_burst");
    endtask

    initial begin : watchdog
        cycles = 0;
        while (cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not complete within %0d cycles", RUN_LIMIT);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        issue         = 1'b0;
        issue_instr   = '0;
        reg_addr      = '0;
        model_instret = '0;
        model_tail    = '0;
        flush_due     = 1'b0;
        rng           = SEED;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        retired       = 0;
        accepted      = 0;
        dropped       = 0;
        exc_seen      = 0;
        for (int i = 0; i < NREGS; i++) begin
            model_regs[i] = '0;
        end
        wait (rst_n === 1'b1);

        test_reset_state();
        test_alu_order();
        test_out_of_order();
        test_mul_in_flight();
        test_trap_flush();
        test_issue_burst();

        errors += DUT.u_rob.u_assert.fail_cnt;
        $display("summary: %0d tests, %0d failed, %0d checks, %0d assertion failures, %0d total",
                 tests_run, tests_failed, checks, DUT.u_rob.u_assert.fail_cnt, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
